//--- src.f
+incdir+design
design/cube_pkg.sv
design/line_dispatch.sv
design/draw_line.sv
design/pixel_arbiter.sv
design/framebuffer.sv
design/cube_draw_top.sv
bench/cube_draw_assertions.sv
bench/cube_draw_tb.sv

//--- Makefile
# Verilator build and run of the cube drawing testbench

SIM := obj_dir/Vcube_draw_tb

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): src.f $(wildcard design/*.sv design/*.svh bench/*.sv)
	verilator --binary --timing --assert --top-module cube_draw_tb \
		-f src.f -o Vcube_draw_tb

# the result comes from the printed pass line
run: $(SIM)
	@out="$$(./$(SIM) +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf obj_dir

//--- bench/cube_draw_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cube drawing testbench
// draws the cube twice and reads back edges and background
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "cube_macros.svh"

module cube_draw_tb;

    logic                          clk_100m;
    logic                          rst;
    logic                          start;
    logic [`CUBE_CIDXW-1:0]        cidx;
    logic                          busy;
    logic                          done;
    logic signed [`CUBE_CORDW-1:0] rd_x;
    logic signed [`CUBE_CORDW-1:0] rd_y;
    logic [`CUBE_CIDXW-1:0]        rd_cidx;

    int seed = 32'h43af;
    int edge_errs = 0;
    int bg_errs = 0;
    int done_errs = 0;
    int timeout_cnt = 0;
    int done_cnt = 0;

    // cube edges as x0, y0, x1, y1
    int edge_tab [`CUBE_LINE_CNT][4] = '{
        '{130,  60, 230,  60}, '{230,  60, 230, 160}, '{230, 160, 130, 160},
        '{130, 160, 130,  60}, '{130, 160,  90, 120}, '{ 90, 120,  90,  20},
        '{ 90,  20, 130,  60}, '{ 90,  20, 190,  20}, '{190,  20, 230,  60}
    };

    logic on_edge [`CUBE_FB_WIDTH][`CUBE_FB_HEIGHT];
    int   pt_x[$], pt_y[$];  // edge points in shuffled order
    int   bg_x[$], bg_y[$];  // background samples

    cube_draw_top i_cube_draw_top (
        .clk_100m, .rst, .start, .cidx, .busy, .done, .rd_x, .rd_y, .rd_cidx
    );

    initial begin
        clk_100m = 1'b0;
        forever #5 clk_100m = ~clk_100m;
    end

    always @(negedge clk_100m) begin
        if (!rst && done === 1'b1) done_cnt++;
    end

    // integer Bresenham walk over any octant with both endpoints
    task automatic trace_edge(input int x0, input int y0, input int x1, input int y1);
        int dx, dy, sx, sy, err, e2, x, y;
        dx  = (x1 > x0) ? x1 - x0 : x0 - x1;
        dy  = (y1 > y0) ? y0 - y1 : y1 - y0;  // kept negative
        sx  = (x1 >= x0) ? 1 : -1;
        sy  = (y1 >= y0) ? 1 : -1;
        err = dx + dy;
        x   = x0;
        y   = y0;
        for (int n = 0; n < 2 * (`CUBE_FB_WIDTH + `CUBE_FB_HEIGHT); n++) begin
            pt_x.push_back(x);
            pt_y.push_back(y);
            on_edge[x][y] = 1'b1;
            if (x == x1 && y == y1) break;
            e2 = 2 * err;
            if (e2 >= dy) begin
                err += dy;
                x   += sx;
            end
            if (e2 <= dx) begin
                err += dx;
                y   += sy;
            end
        end
    endtask

    task automatic build_model();
        int j, t;
        for (int x = 0; x < `CUBE_FB_WIDTH; x++)
            for (int y = 0; y < `CUBE_FB_HEIGHT; y++) on_edge[x][y] = 1'b0;
        for (int e = 0; e < `CUBE_LINE_CNT; e++)
            trace_edge(edge_tab[e][0], edge_tab[e][1], edge_tab[e][2], edge_tab[e][3]);
        for (int i = pt_x.size() - 1; i > 0; i--) begin  // random read order
            j = {$random(seed)} % (i + 1);
            t = pt_x[i];
            pt_x[i] = pt_x[j];
            pt_x[j] = t;
            t = pt_y[i];
            pt_y[i] = pt_y[j];
            pt_y[j] = t;
        end
    endtask

    task automatic pick_background(input int count);
        int x, y;
        while (bg_x.size() < count) begin
            x = {$random(seed)} % `CUBE_FB_WIDTH;
            y = {$random(seed)} % `CUBE_FB_HEIGHT;
            if (!on_edge[x][y]) begin  // reject points on an edge
                bg_x.push_back(x);
                bg_y.push_back(y);
            end
        end
    endtask

    task automatic pulse_start(input logic [`CUBE_CIDXW-1:0] colour);
        @(posedge clk_100m);
        start <= 1'b1;
        cidx  <= colour;
        @(posedge clk_100m);
        start <= 1'b0;
    endtask

    task automatic wait_done(input string name, input int limit, output bit ok);
        ok = 1'b0;
        for (int n = 0; n < limit && !ok; n++) begin
            @(negedge clk_100m);
            if (done) ok = 1'b1;
        end
        if (!ok) begin
            timeout_cnt++;
            $display("%s: no done pulse within %0d cycles", name, limit);
        end
    endtask

    // data comes back one cycle after the address
    task automatic read_pixel(input int x, input int y, output logic [`CUBE_CIDXW-1:0] v);
        @(posedge clk_100m);
        rd_x <= `CUBE_CORDW'(x);
        rd_y <= `CUBE_CORDW'(y);
        @(posedge clk_100m);
        @(negedge clk_100m);
        v = rd_cidx;
    endtask

    task automatic check_edges(input string name, input logic [`CUBE_CIDXW-1:0] exp);
        logic [`CUBE_CIDXW-1:0] v;
        for (int i = 0; i < pt_x.size(); i++) begin
            read_pixel(pt_x[i], pt_y[i], v);
            assert (v == exp) else begin
                edge_errs++;
                $display("Error %s (%0d,%0d): expected %0d, actual %0d",
                         name, pt_x[i], pt_y[i], exp, v);
            end
        end
    endtask

    task automatic check_background(input string name);
        logic [`CUBE_CIDXW-1:0] v;
        for (int i = 0; i < bg_x.size(); i++) begin
            read_pixel(bg_x[i], bg_y[i], v);
            assert (v == '0) else begin
                bg_errs++;
                $display("Error %s (%0d,%0d): expected 0, actual %0d",
                         name, bg_x[i], bg_y[i], v);
            end
        end
    endtask

    initial begin
        bit ok;
        int base;
        int total;
        rst   = 1'b1;
        start = 1'b0;
        cidx  = '0;
        rd_x  = '0;
        rd_y  = '0;
        build_model();
        pick_background(200);
        repeat (8) @(posedge clk_100m);
        rst <= 1'b0;

        base = done_cnt;
        pulse_start(4'h5);
        repeat (5) @(posedge clk_100m);
        pulse_start(4'hc);  // lands mid-draw and is ignored
        wait_done("edge_pixels", 5000, ok);
        if (ok) begin
            check_edges("edge_pixels", 4'h5);
            check_background("background");
            assert (done_cnt - base == 1) else begin
                done_errs++;
                $display("Error busy_done: expected 1, actual %0d", done_cnt - base);
            end
            pulse_start(4'h9);
            wait_done("redraw", 5000, ok);
        end
        if (ok) begin
            check_edges("redraw", 4'h9);
            check_background("redraw");
        end

        total = edge_errs + bg_errs + done_errs + timeout_cnt +
                i_cube_draw_top.i_cube_draw_assertions.fail_cnt;
        $display("errors: edge %0d, background %0d, done %0d, timeout %0d, assertion %0d",
                 edge_errs, bg_errs, done_errs, timeout_cnt,
                 i_cube_draw_top.i_cube_draw_assertions.fail_cnt);
        if (total == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- bench/cube_draw_assertions.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cube drawing protocol checks
// start, busy and done timing, grant and write bounds
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "cube_macros.svh"

module cube_draw_assertions (
    input logic                        clk_100m,
    input logic                        rst,
    input logic                        start,
    input logic                        busy,
    input logic                        done,
    input logic                        wr_en,
    input logic [`CUBE_ENGINE_CNT-1:0] eng_oe,
    input logic [`CUBE_ENGINE_CNT-1:0] eng_start,
    input cube_pkg::pixel_t            wr_pix
);

    int fail_cnt = 0;  // failed assertion count

    task automatic count_failure(input string msg);
        fail_cnt++;
        $error("%s", msg);
    endtask

    a_busy_after_start: assert property (@(posedge clk_100m) disable iff (rst)
        start && !busy |=> busy)
        else count_failure("busy did not rise after an accepted start");

    a_busy_needs_start: assert property (@(posedge clk_100m) disable iff (rst)
        $rose(busy) |-> $past(start))
        else count_failure("busy rose without a start");

    a_done_single: assert property (@(posedge clk_100m) disable iff (rst)
        done |=> !done)
        else count_failure("done held for more than one cycle");

    a_done_at_fall: assert property (@(posedge clk_100m) disable iff (rst)
        done |-> !busy && $past(busy))
        else count_failure("done pulsed while busy did not fall");

    a_fall_gives_done: assert property (@(posedge clk_100m) disable iff (rst)
        $fell(busy) |-> done)
        else count_failure("busy fell without a done pulse");

    a_one_grant: assert property (@(posedge clk_100m) disable iff (rst)
        $onehot0(eng_oe))
        else count_failure("more than one engine granted");

    // writes must land inside the visible frame
    a_write_in_frame: assert property (@(posedge clk_100m) disable iff (rst)
        wr_en |-> wr_pix.x >= 0 && wr_pix.x < `CUBE_FB_WIDTH &&
                  wr_pix.y >= 0 && wr_pix.y < `CUBE_FB_HEIGHT)
        else count_failure("framebuffer write outside the frame");

    a_quiet_after_reset: assert property (@(posedge clk_100m)
        rst |=> !busy && !done && !wr_en && eng_oe == '0 && eng_start == '0)
        else count_failure("output active right after reset");

endmodule

bind cube_draw_top cube_draw_assertions i_cube_draw_assertions (
    .clk_100m, .rst, .start, .busy, .done, .wr_en, .eng_oe, .eng_start, .wr_pix
);

//--- design/cube_draw_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cube drawing top level
// dispatcher, line engines, arbiter and framebuffer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "cube_macros.svh"

module cube_draw_top (
    input  logic                          clk_100m,
    input  logic                          rst,
    input  logic                          start,   // ignored while busy
    input  logic [`CUBE_CIDXW-1:0]        cidx,
    output logic                          busy,
    output logic                          done,
    input  logic signed [`CUBE_CORDW-1:0] rd_x,
    input  logic signed [`CUBE_CORDW-1:0] rd_y,
    output logic [`CUBE_CIDXW-1:0]        rd_cidx  // one cycle after address
);

    logic [`CUBE_ENGINE_CNT-1:0]            eng_start, eng_busy;
    logic [`CUBE_ENGINE_CNT-1:0]            eng_drawing, eng_oe;
    cube_pkg::line_t [`CUBE_ENGINE_CNT-1:0]  eng_line;
    cube_pkg::pixel_t [`CUBE_ENGINE_CNT-1:0] eng_pix;
    logic [`CUBE_CIDXW-1:0]                 draw_cidx;
    logic                                   wr_en;
    cube_pkg::pixel_t                       wr_pix;

    line_dispatch i_line_dispatch (
        .clk_100m, .rst, .start, .cidx, .eng_busy,
        .eng_start, .eng_line, .busy, .done, .draw_cidx
    );

    for (genvar i = 0; i < `CUBE_ENGINE_CNT; i++) begin : g_engine
        draw_line i_draw_line (
            .clk_100m, .rst,
            .start(eng_start[i]), .line(eng_line[i]), .oe(eng_oe[i]), .cidx(draw_cidx),
            .pix(eng_pix[i]), .drawing(eng_drawing[i]), .busy(eng_busy[i])
        );
    end

    pixel_arbiter i_pixel_arbiter (
        .clk_100m, .rst, .eng_pix, .eng_drawing, .eng_oe, .wr_en, .wr_pix
    );

    framebuffer i_framebuffer (
        .clk_100m, .wr_en, .wr_pix, .rd_x, .rd_y, .rd_cidx
    );

endmodule

//--- design/framebuffer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// framebuffer
// 320 x 180 colour indices, one write and one read port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "cube_macros.svh"

module framebuffer (
    input  logic                          clk_100m,
    input  logic                          wr_en,
    input  cube_pkg::pixel_t              wr_pix,
    input  logic signed [`CUBE_CORDW-1:0] rd_x,
    input  logic signed [`CUBE_CORDW-1:0] rd_y,
    output logic [`CUBE_CIDXW-1:0]        rd_cidx
);

    localparam int DEPTH = `CUBE_FB_WIDTH * `CUBE_FB_HEIGHT;
    localparam int ADDRW = $clog2(DEPTH);

    logic [`CUBE_CIDXW-1:0] mem [DEPTH];
    logic [`CUBE_CIDXW-1:0] rd_data;
    logic                   rd_in_q;  // read address was on screen

    function automatic logic in_frame(input logic signed [`CUBE_CORDW-1:0] x,
                                      input logic signed [`CUBE_CORDW-1:0] y);
        return x >= 0 && x < `CUBE_FB_WIDTH && y >= 0 && y < `CUBE_FB_HEIGHT;
    endfunction

    function automatic logic [ADDRW-1:0] lin_addr(input logic signed [`CUBE_CORDW-1:0] x,
                                                  input logic signed [`CUBE_CORDW-1:0] y);
        return ADDRW'(int'(y) * `CUBE_FB_WIDTH + int'(x));  // row major
    endfunction

    initial begin
        for (int i = 0; i < DEPTH; i++) mem[i] = '0;  // blank screen in simulation
    end

    // read before write on a shared address
    always_ff @(posedge clk_100m) begin
        if (wr_en && in_frame(wr_pix.x, wr_pix.y)) mem[lin_addr(wr_pix.x, wr_pix.y)] <= wr_pix.cidx;
        rd_data <= mem[lin_addr(rd_x, rd_y)];
        rd_in_q <= in_frame(rd_x, rd_y);
    end

    assign rd_cidx = rd_in_q ? rd_data : '0;  // off screen reads as background

endmodule

//--- design/pixel_arbiter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pixel arbiter
// round-robin grant of one engine pixel per framebuffer write
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "cube_macros.svh"

module pixel_arbiter (
    input  logic                                    clk_100m,
    input  logic                                    rst,
    input  cube_pkg::pixel_t [`CUBE_ENGINE_CNT-1:0] eng_pix,
    input  logic [`CUBE_ENGINE_CNT-1:0]             eng_drawing,
    output logic [`CUBE_ENGINE_CNT-1:0]             eng_oe,
    output logic                                    wr_en,
    output cube_pkg::pixel_t                        wr_pix
);

    localparam int ENG  = `CUBE_ENGINE_CNT;
    localparam int PTRW = (ENG > 1) ? $clog2(ENG) : 1;

    logic [PTRW-1:0] ptr;        // first engine to look at
    logic [PTRW-1:0] grant_idx;
    logic            grant_found;

    // search from the pointer, wrapping round
    always_comb begin
        int cand;
        cand        = 0;
        grant_found = 1'b0;
        grant_idx   = ptr;
        for (int k = 0; k < ENG; k++) begin
            cand = (int'(ptr) + k) % ENG;
            if (!grant_found && eng_drawing[cand]) begin
                grant_found = 1'b1;
                grant_idx   = PTRW'(cand);
            end
        end
        for (int i = 0; i < ENG; i++) begin
            eng_oe[i] = grant_found && (int'(grant_idx) == i);  // one-hot or zero
        end
    end

    always_ff @(posedge clk_100m) begin
        if (rst) begin
            ptr   <= '0;
            wr_en <= 1'b0;
        end else begin
            wr_en <= grant_found;
            if (grant_found) begin
                // winner goes to the back of the queue
                ptr <= (int'(grant_idx) == ENG - 1) ? '0 : grant_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_100m) begin
        wr_pix <= eng_pix[grant_idx];  // qualified by wr_en
    end

endmodule

//--- design/draw_line.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bresenham line engine
// one pixel per cycle in which output is enabled
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "cube_macros.svh"

module draw_line (
    input  logic                   clk_100m,
    input  logic                   rst,
    input  logic                   start,
    input  cube_pkg::line_t        line,
    input  logic                   oe,
    input  logic [`CUBE_CIDXW-1:0] cidx,
    output cube_pkg::pixel_t       pix,
    output logic                   drawing,
    output logic                   busy
);

    localparam int W = `CUBE_CORDW;

    cube_pkg::line_t   ln;          // latched endpoints
    logic signed [W-1:0] x, y;      // current point
    logic signed [W:0]   dx, dy;    // dx positive, dy negative
    logic signed [W:0]   err;
    logic                x_pos, y_pos;  // step directions

    logic signed [W:0]   x_diff, y_diff;
    logic signed [W:0]   dx_init, dy_init;
    logic signed [W+1:0] e2;
    logic signed [W:0]   err_next;
    logic                step_x, step_y;
    logic                at_end;

    always_comb begin
        x_diff   = (W+1)'(ln.x1) - (W+1)'(ln.x0);
        y_diff   = (W+1)'(ln.y1) - (W+1)'(ln.y0);
        dx_init  = x_diff[W] ? -x_diff : x_diff;
        dy_init  = y_diff[W] ? y_diff : -y_diff;
        e2       = (W+2)'(err) <<< 1;
        step_x   = (e2 >= dy);
        step_y   = (e2 <= dx);
        err_next = err + (step_x ? dy : '0) + (step_y ? dx : '0);
        at_end   = (x == ln.x1) && (y == ln.y1);
    end

    // busy covers setup and walk, drawing only the walk
    always_ff @(posedge clk_100m) begin
        if (rst) begin
            busy    <= 1'b0;
            drawing <= 1'b0;
        end else if (start && !busy) begin
            busy <= 1'b1;
        end else if (busy && !drawing) begin
            drawing <= 1'b1;
        end else if (drawing && oe && at_end) begin
            busy    <= 1'b0;  // endpoint accepted
            drawing <= 1'b0;
        end
    end

    always_ff @(posedge clk_100m) begin
        if (start && !busy) ln <= line;
        if (busy && !drawing) begin  // setup cycle
            x     <= ln.x0;
            y     <= ln.y0;
            dx    <= dx_init;
            dy    <= dy_init;
            err   <= dx_init + dy_init;
            x_pos <= !x_diff[W];
            y_pos <= !y_diff[W];
        end else if (drawing && oe && !at_end) begin
            err <= err_next;
            if (step_x) x <= x_pos ? x + W'(1) : x - W'(1);
            if (step_y) y <= y_pos ? y + W'(1) : y - W'(1);
        end
    end

    always_comb begin
        pix.x    = x;
        pix.y    = y;
        pix.cidx = cidx;
    end

endmodule

//--- design/line_dispatch.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// line dispatcher
// walks the cube edge table and starts idle line engines
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "cube_macros.svh"

module line_dispatch (
    input  logic                                   clk_100m,
    input  logic                                   rst,
    input  logic                                   start,
    input  logic [`CUBE_CIDXW-1:0]                 cidx,
    input  logic [`CUBE_ENGINE_CNT-1:0]            eng_busy,
    output logic [`CUBE_ENGINE_CNT-1:0]            eng_start,
    output cube_pkg::line_t [`CUBE_ENGINE_CNT-1:0] eng_line,
    output logic                                   busy,
    output logic                                   done,
    output logic [`CUBE_CIDXW-1:0]                 draw_cidx
);

    localparam int ENG  = `CUBE_ENGINE_CNT;
    localparam int IDXW = $clog2(`CUBE_LINE_CNT);

    cube_pkg::dispatch_state_e state;
    logic [IDXW-1:0]           line_idx;  // next edge to issue
    logic                      free_found;
    logic [ENG-1:0]            issue_oh;  // engine picked this cycle

    function automatic cube_pkg::line_t mk_line(input int x0, input int y0,
                                                input int x1, input int y1);
        cube_pkg::line_t l;
        l.x0 = `CUBE_CORDW'(x0);
        l.y0 = `CUBE_CORDW'(y0);
        l.x1 = `CUBE_CORDW'(x1);
        l.y1 = `CUBE_CORDW'(y1);
        return l;
    endfunction

    // front face, back edges, then the top face
    function automatic cube_pkg::line_t edge_line(input logic [IDXW-1:0] idx);
        case (int'(idx))
            0:       return mk_line(130,  60, 230,  60);
            1:       return mk_line(230,  60, 230, 160);
            2:       return mk_line(230, 160, 130, 160);
            3:       return mk_line(130, 160, 130,  60);
            4:       return mk_line(130, 160,  90, 120);
            5:       return mk_line( 90, 120,  90,  20);
            6:       return mk_line( 90,  20, 130,  60);
            7:       return mk_line( 90,  20, 190,  20);
            8:       return mk_line(190,  20, 230,  60);
            default: return mk_line(  0,   0,   0,   0);
        endcase
    endfunction

    // an engine started last cycle still shows busy low
    always_comb begin
        free_found = 1'b0;
        issue_oh   = '0;
        for (int i = 0; i < ENG; i++) begin
            if (!free_found && !eng_busy[i] && !eng_start[i]) begin
                free_found  = 1'b1;
                issue_oh[i] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk_100m) begin
        if (rst) begin
            state     <= cube_pkg::IDLE;
            line_idx  <= '0;
            eng_start <= '0;
            done      <= 1'b0;
        end else begin
            eng_start <= '0;
            done      <= 1'b0;
            case (state)
                cube_pkg::IDLE: begin
                    if (start) begin
                        line_idx <= '0;
                        state    <= cube_pkg::ISSUE;
                    end
                end
                cube_pkg::ISSUE: begin
                    if (free_found) begin
                        eng_start <= issue_oh;
                        line_idx  <= line_idx + 1'b1;
                        if (int'(line_idx) == `CUBE_LINE_CNT - 1) state <= cube_pkg::WAIT;
                    end
                end
                cube_pkg::WAIT: begin
                    if (eng_busy == '0 && eng_start == '0) state <= cube_pkg::DRAIN;
                end
                default: begin  // DRAIN
                    done  <= 1'b1;
                    state <= cube_pkg::IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_100m) begin
        if (state == cube_pkg::IDLE && start) draw_cidx <= cidx;  // colour for this cube
        for (int i = 0; i < ENG; i++) begin
            if (state == cube_pkg::ISSUE && issue_oh[i]) eng_line[i] <= edge_line(line_idx);
        end
    end

    assign busy = (state != cube_pkg::IDLE);  // falls with the done pulse

endmodule

//--- design/cube_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cube drawing types
// line endpoints, framebuffer pixel and dispatcher states
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "cube_macros.svh"

package cube_pkg;

    // one line segment, both endpoints inclusive
    typedef struct packed {
        logic signed [`CUBE_CORDW-1:0] x0;
        logic signed [`CUBE_CORDW-1:0] y0;
        logic signed [`CUBE_CORDW-1:0] x1;
        logic signed [`CUBE_CORDW-1:0] y1;
    } line_t;

    // one pixel write into the framebuffer
    typedef struct packed {
        logic signed [`CUBE_CORDW-1:0] x;
        logic signed [`CUBE_CORDW-1:0] y;
        logic [`CUBE_CIDXW-1:0]        cidx;
    } pixel_t;

    typedef enum logic [1:0] {
        IDLE,   // waiting for start
        ISSUE,  // handing edges to free engines
        WAIT,   // all edges issued, engines finishing
        DRAIN   // last framebuffer write lands
    } dispatch_state_e;

endpackage

//--- design/cube_macros.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cube drawing parameters
// coordinate, framebuffer, colour and engine sizing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef CUBE_MACROS_SVH
`define CUBE_MACROS_SVH

// signed screen coordinates
`define CUBE_CORDW       16

// framebuffer geometry in pixels
`define CUBE_FB_WIDTH    320
`define CUBE_FB_HEIGHT   180

// colour index into a 16 entry palette
`define CUBE_CIDXW       4

// line engines working in parallel, 1 to 4
`define CUBE_ENGINE_CNT  3

// edges in the wireframe cube
`define CUBE_LINE_CNT    9

`endif
